/* design/fixed_format_pkg.sv */
package fixed_format_pkg;

    // variance input, unsigned Q9.7
    localparam int VAR_WIDTH = 16;
    localparam int VAR_FRAC  = 7;

    typedef logic [VAR_WIDTH-1:0] var_t;

    // inverse square root, keeps the input fraction width
    localparam int RSQRT_WIDTH = 16;
    localparam int RSQRT_FRAC  = 7;

    typedef logic [RSQRT_WIDTH-1:0] rsqrt_t;

    // zero input and overflow both land here
    localparam rsqrt_t RSQRT_MAX = '1;

    // sample, signed Q8.7, also the scaled result
    localparam int SAMPLE_WIDTH = 16;
    localparam int SAMPLE_FRAC  = 7;

    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;

    // saturation limits of the scaled result
    localparam sample_t SAMPLE_MAX = {1'b0, {(SAMPLE_WIDTH-1){1'b1}}};
    localparam sample_t SAMPLE_MIN = {1'b1, {(SAMPLE_WIDTH-1){1'b0}}};

    // fraction bits of sample times rsqrt
    localparam int PROD_FRAC = SAMPLE_FRAC + RSQRT_FRAC;

    // reduced range is Q1.15, values in [1.0, 2.0)
    localparam int Q15_FRAC = 15;
    localparam logic [15:0] ONE_Q15 = 16'h8000;

endpackage

/* design/isqrt_cfg_pkg.sv */
package isqrt_cfg_pkg;

    // seed table, indexed by the top fraction bits of the reduced value
    localparam int LUT_POW  = 5;
    localparam int LUT_SIZE = 1 << LUT_POW;

    // bit position of the leading one in a 16-bit variance
    localparam int MSB_WIDTH = 4;

    // seeds are Q1.15
    localparam int SEED_WIDTH = 16;

    typedef logic [SEED_WIDTH-1:0] seed_t;
    typedef logic [LUT_SIZE-1:0][SEED_WIDTH-1:0] seed_table_t;

    // newton constant 1.5 in Q2.15
    localparam logic [16:0] THREE_HALVES = 17'd49152;

    // sqrt(2) in Q1.15 for odd exponent correction
    localparam logic [15:0] SQRT_TWO = 16'd46341;

    // seed i is 1/sqrt of the bin midpoint 1 + (i + 0.5) / LUT_SIZE
    // seed = sqrt(2^30 * 2 * LUT_SIZE / (2 * LUT_SIZE + 2 * i + 1))
    function automatic seed_table_t isqrt_seed_table();
        seed_table_t table_q;
        logic [63:0] radicand;
        logic [63:0] root;
        logic [63:0] trial;
        table_q = '0;
        for (int i = 0; i < LUT_SIZE; i++) begin
            radicand = (64'd1 << 31) * LUT_SIZE / (2 * LUT_SIZE + 2 * i + 1);
            root = '0;
            // bitwise integer square root, msb first
            for (int b = SEED_WIDTH - 1; b >= 0; b--) begin
                trial = root | (64'd1 << b);
                if (trial * trial <= radicand) begin
                    root = trial;
                end
            end
            table_q[i] = root[SEED_WIDTH-1:0];
        end
        return table_q;
    endfunction

    // built once at elaboration
    localparam seed_table_t SEED_TABLE = isqrt_seed_table();

endpackage

/* design/pipe_stage.sv */
`timescale 1ns/1ps

module pipe_stage #(
    parameter type payload_t = logic [15:0]
) (
    input  logic     clk,
    input  logic     reset,

    // upstream side
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,

    // downstream side
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     valid_q;
    payload_t data_q;

    // slot can take a beat when empty or when draining this cycle
    assign in_ready = ~valid_q | out_ready;

    // valid flag follows the input whenever the slot opens
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (in_ready) begin
            valid_q <= in_valid;
        end
    end

    // payload loads with the flag, held while stalled
    always_ff @(posedge clk) begin
        if (in_ready) begin
            data_q <= in_data;
        end
    end

    assign out_valid = valid_q;
    assign out_data  = data_q;

endmodule

/* design/fixed_isqrt.sv */
`timescale 1ns/1ps

module fixed_isqrt (
    input  logic                     clk,
    input  logic                     reset,

    input  logic                     in_valid,
    output logic                     in_ready,
    input  fixed_format_pkg::var_t   in_var,

    output logic                     out_valid,
    input  logic                     out_ready,
    output fixed_format_pkg::rsqrt_t out_rsqrt
);

    // stage one bundle, reduced value plus what stage two needs
    typedef struct packed {
        logic [15:0]                          x_red;
        logic [isqrt_cfg_pkg::MSB_WIDTH-1:0] msb;
        isqrt_cfg_pkg::seed_t                 seed;
        logic                                 zero;
    } reduced_t;

    logic [isqrt_cfg_pkg::MSB_WIDTH-1:0] msb_index;
    logic [isqrt_cfg_pkg::MSB_WIDTH-1:0] norm_shift;
    logic [isqrt_cfg_pkg::LUT_POW-1:0]   lut_index;
    reduced_t                            s1_in;
    reduced_t                            s1_out;
    logic                                s1_valid;
    logic                                s1_ready;

    // stage two datapath
    logic [31:0]              y_sq;
    logic [32:0]              x_y_sq;
    logic [16:0]              nr_term;
    logic [32:0]              nr_prod;
    logic [16:0]              y_nr;
    logic [16:0]              y_one;
    logic [32:0]              y_odd;
    logic [16:0]              y_adj;
    logic signed [5:0]        msb_offset;
    logic signed [5:0]        half_offset;
    logic signed [5:0]        shift_sum;
    logic [3:0]               shift_amt;
    logic [31:0]              y_aug;
    fixed_format_pkg::rsqrt_t rsqrt_next;

    // leading one search, highest set bit wins
    always_comb begin
        msb_index = '0;
        for (int i = 0; i < fixed_format_pkg::VAR_WIDTH; i++) begin
            if (in_var[i]) begin
                msb_index = i[isqrt_cfg_pkg::MSB_WIDTH-1:0];
            end
        end
    end

    // 15 - msb for a 16-bit variance
    assign norm_shift = ~msb_index;

    // move the leading one to bit 15, giving Q1.15 in [1.0, 2.0)
    assign s1_in.x_red = in_var << norm_shift;
    assign s1_in.msb   = msb_index;
    assign s1_in.zero  = (in_var == '0);

    // table bins split [1.0, 2.0) by the top fraction bits
    assign lut_index  = s1_in.x_red[14 -: isqrt_cfg_pkg::LUT_POW];
    assign s1_in.seed = isqrt_cfg_pkg::SEED_TABLE[lut_index];

    pipe_stage #(
        .payload_t (reduced_t)
    ) u_stage_reduce (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (s1_in),
        .out_valid (s1_valid),
        .out_ready (s1_ready),
        .out_data  (s1_out)
    );

    // newton step y1 = y0 * (1.5 - x * y0^2 / 2)
    assign y_sq    = s1_out.seed * s1_out.seed;
    // x * y0^2 is Q2.30 here, dropping 16 bits halves it into Q.15
    assign x_y_sq  = s1_out.x_red * y_sq[31:15];
    assign nr_term = isqrt_cfg_pkg::THREE_HALVES - x_y_sq[32:16];
    assign nr_prod = s1_out.seed * nr_term;
    assign y_nr    = nr_prod[31:15];

    // exact one for a power-of-two variance
    assign y_one = (s1_out.x_red == fixed_format_pkg::ONE_Q15) ?
                   {1'b0, fixed_format_pkg::ONE_Q15} : y_nr;

    // exponent of the variance relative to its binary point
    assign msb_offset  = $signed({2'b00, s1_out.msb}) -
                         $signed(6'(fixed_format_pkg::VAR_FRAC));
    // ceil(offset / 2), odd offsets pick up sqrt(2) below
    assign half_offset = (msb_offset + 6'sd1) >>> 1;
    // Q1.15 to Q9.7 plus the exponent halving, always a right shift
    assign shift_sum   = half_offset + $signed(6'(fixed_format_pkg::Q15_FRAC -
                                                 fixed_format_pkg::RSQRT_FRAC));
    assign shift_amt   = shift_sum[3:0];

    // odd exponent, rounded up, so scale back by sqrt(2)
    assign y_odd = y_one * isqrt_cfg_pkg::SQRT_TWO;
    assign y_adj = msb_offset[0] ? y_odd[31:15] : y_one;

    assign y_aug = {15'd0, y_adj} >> shift_amt;

    // zero variance or overflow clamp to max
    always_comb begin
        if (s1_out.zero) begin
            rsqrt_next = fixed_format_pkg::RSQRT_MAX;
        end else if (y_aug > fixed_format_pkg::RSQRT_MAX) begin
            rsqrt_next = fixed_format_pkg::RSQRT_MAX;
        end else begin
            rsqrt_next = y_aug[fixed_format_pkg::RSQRT_WIDTH-1:0];
        end
    end

    pipe_stage #(
        .payload_t (fixed_format_pkg::rsqrt_t)
    ) u_stage_newton (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (s1_valid),
        .in_ready  (s1_ready),
        .in_data   (rsqrt_next),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_rsqrt)
    );

endmodule

/* design/fixed_scale_mul.sv */
`timescale 1ns/1ps

module fixed_scale_mul (
    input  logic                      clk,
    input  logic                      reset,

    // inverse square root stream
    input  logic                      iq_valid,
    output logic                      iq_ready,
    input  fixed_format_pkg::rsqrt_t  iq_rsqrt,

    // delayed sample stream
    input  logic                      sd_valid,
    output logic                      sd_ready,
    input  fixed_format_pkg::sample_t sd_sample,

    output logic                      out_valid,
    input  logic                      out_ready,
    output fixed_format_pkg::rsqrt_t  out_rsqrt,
    output fixed_format_pkg::sample_t out_scaled
);

    // result pair carried by the output register
    typedef struct packed {
        fixed_format_pkg::rsqrt_t  rsqrt;
        fixed_format_pkg::sample_t scaled;
    } result_t;

    logic               both_valid;
    logic               st_ready;
    logic signed [32:0] product;
    logic signed [32:0] prod_shifted;
    result_t            res_in;
    result_t            res_out;

    // both streams must be present, then one joint ready
    assign both_valid = iq_valid & sd_valid;
    assign iq_ready   = both_valid & st_ready;
    assign sd_ready   = both_valid & st_ready;

    // rsqrt is unsigned, zero extend before the signed multiply
    assign product = sd_sample * $signed({1'b0, iq_rsqrt});

    // arithmetic shift floors toward negative infinity
    assign prod_shifted = product >>> (fixed_format_pkg::PROD_FRAC -
                                       fixed_format_pkg::SAMPLE_FRAC);

    assign res_in.rsqrt = iq_rsqrt;

    // clamp to the Q8.7 range
    always_comb begin
        if (prod_shifted > fixed_format_pkg::SAMPLE_MAX) begin
            res_in.scaled = fixed_format_pkg::SAMPLE_MAX;
        end else if (prod_shifted < fixed_format_pkg::SAMPLE_MIN) begin
            res_in.scaled = fixed_format_pkg::SAMPLE_MIN;
        end else begin
            res_in.scaled = prod_shifted[fixed_format_pkg::SAMPLE_WIDTH-1:0];
        end
    end

    pipe_stage #(
        .payload_t (result_t)
    ) u_stage_out (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (both_valid),
        .in_ready  (st_ready),
        .in_data   (res_in),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (res_out)
    );

    assign out_rsqrt  = res_out.rsqrt;
    assign out_scaled = res_out.scaled;

endmodule

/* design/fixed_rsqrt_scale.sv */
`timescale 1ns/1ps

module fixed_rsqrt_scale (
    input  logic                      clk,
    input  logic                      reset,

    input  logic                      in_valid,
    output logic                      in_ready,
    input  fixed_format_pkg::var_t    in_var,
    input  fixed_format_pkg::sample_t in_sample,

    output logic                      out_valid,
    input  logic                      out_ready,
    output fixed_format_pkg::rsqrt_t  out_rsqrt,
    output fixed_format_pkg::sample_t out_scaled
);

    // fork side readies
    logic                      iq_in_ready;
    logic                      sp_in_ready;

    // rsqrt path into the combiner
    logic                      iq_valid;
    logic                      iq_ready;
    fixed_format_pkg::rsqrt_t  iq_rsqrt;

    // between the two sample stages
    logic                      sp_mid_valid;
    logic                      sp_mid_ready;
    fixed_format_pkg::sample_t sp_mid_sample;

    // sample path into the combiner
    logic                      sd_valid;
    logic                      sd_ready;
    fixed_format_pkg::sample_t sd_sample;

    // a beat enters both paths or neither
    assign in_ready = iq_in_ready & sp_in_ready;

    fixed_isqrt u_isqrt (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid & sp_in_ready),
        .in_ready  (iq_in_ready),
        .in_var    (in_var),
        .out_valid (iq_valid),
        .out_ready (iq_ready),
        .out_rsqrt (iq_rsqrt)
    );

    // sample delay, two stages to match the isqrt latency
    pipe_stage #(
        .payload_t (fixed_format_pkg::sample_t)
    ) u_sample_d1 (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid & iq_in_ready),
        .in_ready  (sp_in_ready),
        .in_data   (in_sample),
        .out_valid (sp_mid_valid),
        .out_ready (sp_mid_ready),
        .out_data  (sp_mid_sample)
    );

    pipe_stage #(
        .payload_t (fixed_format_pkg::sample_t)
    ) u_sample_d2 (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (sp_mid_valid),
        .in_ready  (sp_mid_ready),
        .in_data   (sp_mid_sample),
        .out_valid (sd_valid),
        .out_ready (sd_ready),
        .out_data  (sd_sample)
    );

    // join and scale
    fixed_scale_mul u_scale_mul (
        .clk        (clk),
        .reset      (reset),
        .iq_valid   (iq_valid),
        .iq_ready   (iq_ready),
        .iq_rsqrt   (iq_rsqrt),
        .sd_valid   (sd_valid),
        .sd_ready   (sd_ready),
        .sd_sample  (sd_sample),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_rsqrt  (out_rsqrt),
        .out_scaled (out_scaled)
    );

endmodule

/* verif/fixed_rsqrt_scale_props.sv */
`timescale 1ns/1ps

module fixed_rsqrt_scale_props (
    input logic                      clk,
    input logic                      reset,
    input logic                      in_ready,
    input logic                      out_valid,
    input logic                      out_ready,
    input fixed_format_pkg::rsqrt_t  out_rsqrt,
    input fixed_format_pkg::sample_t out_scaled,
    input logic                      s1_valid,
    input logic                      iq_valid,
    input logic                      sp_mid_valid,
    input logic                      sd_valid
);

    logic pipe_empty;

    // count of failed properties
    int error_count = 0;

    // no beat held in either path or in the output register
    assign pipe_empty = ~s1_valid & ~iq_valid & ~sp_mid_valid & ~sd_valid & ~out_valid;

    // output register clears while reset is held
    assert property (@(posedge clk) reset |=> !out_valid)
        else begin
            $error("out_valid high during reset");
            error_count++;
        end

    // a stalled result keeps its valid and its payload
    assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_rsqrt) && $stable(out_scaled))
        else begin
            $error("output beat changed while out_ready was low");
            error_count++;
        end

    // nothing in flight, nothing to block the input
    assert property (@(posedge clk) disable iff (reset) pipe_empty |-> in_ready)
        else begin
            $error("in_ready low with an empty pipeline");
            error_count++;
        end

endmodule

bind fixed_rsqrt_scale fixed_rsqrt_scale_props u_props (
    .clk          (clk),
    .reset        (reset),
    .in_ready     (in_ready),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .out_rsqrt    (out_rsqrt),
    .out_scaled   (out_scaled),
    .s1_valid     (u_isqrt.s1_valid),
    .iq_valid     (iq_valid),
    .sp_mid_valid (sp_mid_valid),
    .sd_valid     (sd_valid)
);

/* verif/fixed_rsqrt_scale_tb.sv */
`timescale 1ns/1ps

module fixed_rsqrt_scale_tb;

    localparam int RAND_SEED = 12902;
    localparam int LATENCY   = 3;
    // exact, zero, latency plus stream, back-pressure, saturation
    localparam int TOTAL_BEATS    = 4 + 3 + 65 + 200 + 4;
    localparam int TIMEOUT_CYCLES = 2 * TOTAL_BEATS + 200;

    // one accepted input beat, waiting for its result
    typedef struct {
        fixed_format_pkg::var_t    variance;
        fixed_format_pkg::sample_t sample;
        bit                        exact;
        int                        accept_cycle;
    } beat_t;

    logic                      clk;
    logic                      reset;
    logic                      in_valid;
    logic                      in_ready;
    fixed_format_pkg::var_t    in_var;
    fixed_format_pkg::sample_t in_sample;
    logic                      out_valid;
    logic                      out_ready;
    fixed_format_pkg::rsqrt_t  out_rsqrt;
    fixed_format_pkg::sample_t out_scaled;

    beat_t expected_q[$];
    int    cycle_count = 0;
    bit    check_timing = 1'b0;
    int    timed_outputs = 0;
    int    last_out_cycle = 0;
    bit    watch_stall = 1'b0;
    bit    stall_seen = 1'b0;

    fixed_rsqrt_scale dut (
        .clk        (clk),
        .reset      (reset),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_var     (in_var),
        .in_sample  (in_sample),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_rsqrt  (out_rsqrt),
        .out_scaled (out_scaled)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    // remembers whether back-pressure ever closed the input
    always @(posedge clk) begin
        if (watch_stall && !in_ready) begin
            stall_seen <= 1'b1;
        end
    end

    // every output handshake is matched against the oldest input
    always @(posedge clk) begin
        if (!reset && out_valid && out_ready) begin
            check_output(out_rsqrt, out_scaled);
        end
    end

    // a failed handshake property ends the run
    always @(dut.u_props.error_count) begin
        if (dut.u_props.error_count != 0) begin
            $display("a handshake property failed at %0t ns", $time);
            abort_run();
        end
    end

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("TESTBENCH FAILED");
        $fatal(1);
    end

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    function automatic real abs_real(input real x);
        return (x < 0.0) ? -x : x;
    endfunction

    // model: 1/sqrt of the variance, both sides in Q9.7 units
    function automatic real ref_rsqrt(input fixed_format_pkg::var_t v);
        real r;
        if (v == '0) begin
            r = real'(fixed_format_pkg::RSQRT_MAX);
        end else begin
            r = (2.0 ** fixed_format_pkg::RSQRT_FRAC) /
                $sqrt(real'(v) / (2.0 ** fixed_format_pkg::VAR_FRAC));
        end
        if (r > real'(fixed_format_pkg::RSQRT_MAX)) begin
            r = real'(fixed_format_pkg::RSQRT_MAX);
        end
        return r;
    endfunction

    // 2 lsb or 1/256 relative, the larger one
    function automatic real rsqrt_tol(input real expected);
        return (expected / 256.0 > 2.0) ? expected / 256.0 : 2.0;
    endfunction

    task automatic check_flag(input logic got, input logic expected, input string what);
        if (got !== expected) begin
            $display("error: %0t ns: %s is %b, expected %b", $time, what, got, expected);
            abort_run();
        end
    endtask

    task automatic check_rsqrt(input fixed_format_pkg::rsqrt_t got, input real expected,
                               input real tol);
        if (abs_real(real'(got) - expected) > tol) begin
            $display("error: %0t ns: rsqrt is %0d, expected %0.3f within %0.3f",
                     $time, got, expected, tol);
            abort_run();
        end
    endtask

    task automatic check_scaled(input fixed_format_pkg::sample_t got, input real expected,
                                input real tol);
        real hi;
        real lo;
        real want;
        hi = real'(fixed_format_pkg::SAMPLE_MAX);
        lo = real'(fixed_format_pkg::SAMPLE_MIN);
        // clearly past a limit, the result has to sit exactly on it
        if (expected - tol > hi) begin
            want = hi;
            tol  = 0.0;
        end else if (expected + tol < lo) begin
            want = lo;
            tol  = 0.0;
        end else begin
            want = (expected > hi) ? hi : ((expected < lo) ? lo : expected);
        end
        if (abs_real(real'(got) - want) > tol) begin
            $display("error: %0t ns: scaled is %0d, expected %0.3f within %0.3f",
                     $time, got, want, tol);
            abort_run();
        end
    endtask

    task automatic check_output(input fixed_format_pkg::rsqrt_t got_rsqrt,
                                input fixed_format_pkg::sample_t got_scaled);
        beat_t beat;
        real   exp_rsqrt;
        real   tol_rsqrt;
        real   tol_scaled;
        if (expected_q.size() == 0) begin
            $display("an output beat came out at %0t ns with no input beat left for it", $time);
            abort_run();
        end else begin
            beat = expected_q.pop_front();
            // latency 3 and back to back results while timing is watched
            if (check_timing && (cycle_count - beat.accept_cycle != LATENCY ||
                                 (timed_outputs > 0 && cycle_count != last_out_cycle + 1))) begin
                $display("error: %0t ns: result %0d cycles after its input, %0d after the last",
                         $time, cycle_count - beat.accept_cycle, cycle_count - last_out_cycle);
                abort_run();
            end
            timed_outputs++;
            last_out_cycle = cycle_count;
            exp_rsqrt  = ref_rsqrt(beat.variance);
            tol_rsqrt  = beat.exact ? 0.0 : rsqrt_tol(exp_rsqrt);
            // rsqrt error grows with the sample magnitude
            tol_scaled = beat.exact ? 0.0 :
                         2.0 + abs_real(real'(beat.sample)) * tol_rsqrt / 128.0;
            check_rsqrt(got_rsqrt, exp_rsqrt, tol_rsqrt);
            check_scaled(got_scaled, real'(beat.sample) * exp_rsqrt / 128.0, tol_scaled);
        end
    endtask

    // spread over all exponents, never zero
    function automatic fixed_format_pkg::var_t rand_variance();
        logic [31:0] raw;
        raw = $urandom() >> $urandom_range(31, 16);
        return (raw[15:0] == '0) ? 16'd1 : raw[15:0];
    endfunction

    function automatic fixed_format_pkg::sample_t rand_sample();
        logic [31:0] raw;
        raw = $urandom();
        return raw[15:0];
    endfunction

    // holds the beat until the handshake, then queues its result
    task automatic send_beat(input fixed_format_pkg::var_t v,
                             input fixed_format_pkg::sample_t s, input bit exact);
        beat_t beat;
        in_valid  = 1'b1;
        in_var    = v;
        in_sample = s;
        @(posedge clk);
        while (!in_ready) @(posedge clk);
        beat.variance     = v;
        beat.sample       = s;
        beat.exact        = exact;
        beat.accept_cycle = cycle_count;
        expected_q.push_back(beat);
        #1;
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        while (expected_q.size() != 0) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    task automatic test_reset_state();
        check_flag(out_valid, 1'b0, "out_valid after reset");
        check_flag(in_ready, 1'b1, "in_ready after reset");
        @(posedge clk);
        #1;
        check_flag(out_valid, 1'b0, "out_valid one cycle after reset");
        check_flag(in_ready, 1'b1, "in_ready one cycle after reset");
    endtask

    // powers of four give exact roots and exact products
    task automatic test_exact_points();
        send_beat(16'd128, 16'sd256, 1'b1);
        send_beat(16'd512, 16'sd256, 1'b1);
        send_beat(16'd2048, -16'sd400, 1'b1);
        send_beat(16'd32, 16'sd300, 1'b1);
        wait_drain();
    endtask

    task automatic test_zero_variance();
        send_beat(16'd0, 16'sd1000, 1'b1);
        send_beat(16'd0, -16'sd1000, 1'b1);
        send_beat(16'd0, 16'sd0, 1'b1);
        wait_drain();
    endtask

    task automatic test_latency_stream();
        check_timing  = 1'b1;
        timed_outputs = 0;
        send_beat(rand_variance(), rand_sample(), 1'b0);
        wait_drain();
        timed_outputs = 0;
        for (int i = 0; i < 64; i++) begin
            send_beat(rand_variance(), rand_sample(), 1'b0);
        end
        wait_drain();
        check_timing = 1'b0;
    endtask

    task automatic test_back_pressure();
        fixed_format_pkg::var_t    vars[200];
        fixed_format_pkg::sample_t samples[200];
        for (int i = 0; i < 200; i++) begin
            vars[i]    = rand_variance();
            samples[i] = rand_sample();
        end
        watch_stall = 1'b1;
        fork
            begin
                for (int i = 0; i < 200; i++) begin
                    send_beat(vars[i], samples[i], 1'b0);
                end
            end
            begin
                // mostly ready, one 12 cycle hold fills every stage
                for (int c = 0; c < 240; c++) begin
                    out_ready = (c >= 40 && c < 52) ? 1'b0 : (($urandom() % 4) != 0);
                    @(posedge clk);
                    #1;
                end
                out_ready = 1'b1;
            end
        join
        wait_drain();
        watch_stall = 1'b0;
        if (!stall_seen) begin
            $display("the long out_ready hold never pulled in_ready low");
            abort_run();
        end
    endtask

    // variance of 1 or 2 lsb scales by roughly 8 to 11
    task automatic test_saturation();
        send_beat(16'd2, 16'sd20000, 1'b0);
        send_beat(16'd2, -16'sd20000, 1'b0);
        send_beat(16'd1, 16'sd32767, 1'b0);
        send_beat(16'd1, -16'sd32768, 1'b0);
        wait_drain();
    endtask

    initial begin
        void'($urandom(RAND_SEED));
        reset     = 1'b1;
        in_valid  = 1'b0;
        in_var    = '0;
        in_sample = '0;
        out_ready = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        test_reset_state();
        test_exact_points();
        test_zero_variance();
        test_latency_stream();
        test_back_pressure();
        test_saturation();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* fixed_rsqrt_scale.f */
design/fixed_format_pkg.sv
design/isqrt_cfg_pkg.sv
design/pipe_stage.sv
design/fixed_isqrt.sv
design/fixed_scale_mul.sv
design/fixed_rsqrt_scale.sv
verif/fixed_rsqrt_scale_props.sv
verif/fixed_rsqrt_scale_tb.sv
